// ==== rtl/stream_consts.svh ====
// address map, bus widths and gate depth of the null stream source
// included by the packages and by any module that decodes addresses

`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// **************************************************
// settings register addresses
// **************************************************
`define SR_NEXT_DST         8'd128
`define SR_LINES_PER_PACKET 8'd129
`define SR_LINE_RATE        8'd130
`define SR_ENABLE_STREAM    8'd131

// **************************************************
// bus widths
// **************************************************
`define SET_ADDR_W 8
`define SET_DATA_W 32
`define LINE_W     64

// log2 of gate buffer depth in lines
`define GATE_SIZE 10

`endif

// ==== rtl/settings_pkg.sv ====
// types for the settings bus and the values the host configures
`default_nettype none

`include "stream_consts.svh"

package settings_pkg;

   typedef logic [`SET_ADDR_W-1:0] set_addr_t;   // settings address
   typedef logic [`SET_DATA_W-1:0] set_data_t;   // settings write data

   // payload lines per packet
   typedef logic [15:0] line_count_t;

   typedef logic [15:0] rate_t;   // idle cycles between lines

endpackage

`default_nettype wire

// ==== rtl/chdr_pkg.sv ====
// types for stream lines, header fields and the generator FSM
`default_nettype none

`include "stream_consts.svh"

package chdr_pkg;

   typedef logic [`LINE_W-1:0] line_t;   // one stream line

   // header fields
   typedef logic [31:0] sid_t;
   typedef logic [11:0] seqnum_t;
   typedef logic [15:0] pkt_len_t;   // bytes, header included

   typedef enum logic [1:0]
   {
      IDLE = 2'd0,
      HEAD = 2'd1,
      DATA = 2'd2
   } gen_state_t;

endpackage

`default_nettype wire

// ==== rtl/setting_bank.sv ====
// settings bank of the null source
// decodes strobed writes into stream id, length, rate and enable
`timescale 1ns/1ps
`default_nettype none

`include "stream_consts.svh"

module setting_bank
(
   input  wire                         clk,
   input  wire                         reset,
   input  wire                         i_set_stb,
   input  settings_pkg::set_addr_t     i_set_addr,
   input  settings_pkg::set_data_t     i_set_data,
   output chdr_pkg::sid_t              o_sid,
   output settings_pkg::line_count_t   o_len,
   output settings_pkg::rate_t         o_rate,
   output logic                        o_enable,
   output logic                        o_sid_changed
);

   logic wr_sid;
   logic wr_len;
   logic wr_rate;
   logic wr_enable;

   // address decode
   assign wr_sid    = i_set_stb && (i_set_addr == `SR_NEXT_DST);
   assign wr_len    = i_set_stb && (i_set_addr == `SR_LINES_PER_PACKET);
   assign wr_rate   = i_set_stb && (i_set_addr == `SR_LINE_RATE);
   assign wr_enable = i_set_stb && (i_set_addr == `SR_ENABLE_STREAM);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         o_sid         <= '0;
         o_len         <= '0;
         o_rate        <= '0;
         o_enable      <= 1'b0;
         o_sid_changed <= 1'b0;
      end
      else
      begin
         o_sid_changed <= wr_sid;   // pulses even if value unchanged
         if (wr_sid)
            o_sid <= i_set_data;
         if (wr_len)
            o_len <= i_set_data[15:0];
         if (wr_rate)
            o_rate <= i_set_data[15:0];
         if (wr_enable)
            o_enable <= i_set_data[0];
      end
   end

endmodule

`default_nettype wire

// ==== rtl/null_packet_gen.sv ====
// dummy packet generator, one header line then numbered payload lines
// line spacing set by a free-running rate timer, stalls on tready
`timescale 1ns/1ps
`default_nettype none

module null_packet_gen
(
   input  wire                         clk,
   input  wire                         reset,
   input  chdr_pkg::sid_t              i_sid,
   input  settings_pkg::line_count_t   i_len,
   input  settings_pkg::rate_t         i_rate,
   input  wire                         i_enable,
   input  wire                         i_sid_changed,
   output chdr_pkg::line_t             o_tdata,
   output logic                        o_tlast,
   output logic                        o_tvalid,
   input  wire                         i_tready
);

   chdr_pkg::gen_state_t        state;
   settings_pkg::line_count_t   count;        // 0 on header, c on payload line c
   chdr_pkg::seqnum_t           seqnum;
   settings_pkg::rate_t         line_timer;
   chdr_pkg::pkt_len_t          pkt_len;
   logic                        xfer;
   logic                        stall;
   logic                        last_line;

   assign xfer      = o_tvalid && i_tready;
   assign stall     = o_tvalid && !i_tready;
   assign last_line = (count >= i_len);   // true on the header when len is 0

   // **************************************************
   // packet state machine
   // **************************************************
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state  <= chdr_pkg::IDLE;
         count  <= '0;
         seqnum <= '0;
      end
      else
      begin
         if (i_sid_changed)
            seqnum <= '0;
         case (state)
            chdr_pkg::IDLE:
            begin
               if (i_enable)
                  state <= chdr_pkg::HEAD;
            end
            chdr_pkg::HEAD:
            begin
               if (xfer)
               begin
                  seqnum <= seqnum + 1'b1;
                  if (last_line)
                     state <= chdr_pkg::IDLE;   // header only packet
                  else
                  begin
                     count <= 16'd1;
                     state <= chdr_pkg::DATA;
                  end
               end
            end
            chdr_pkg::DATA:
            begin
               if (xfer)
               begin
                  if (last_line)
                  begin
                     count <= '0;
                     state <= chdr_pkg::IDLE;
                  end
                  else
                     count <= count + 1'b1;
               end
            end
            default:
               state <= chdr_pkg::IDLE;
         endcase
      end
   end

   // **************************************************
   // line rate timer
   // **************************************************
   always_ff @(posedge clk)
   begin
      if (reset)
         line_timer <= '0;
      else if (!stall)   // hold at zero so an offered line stays valid
      begin
         if (line_timer == '0)
            line_timer <= i_rate;
         else
            line_timer <= line_timer - 1'b1;
      end
   end

   // header and payload words
   assign pkt_len = {i_len[12:0], 3'b000} + 16'd8;

   assign o_tdata  = (state == chdr_pkg::HEAD) ? {4'b0000, seqnum, pkt_len, i_sid}
                                               : {~count, count, count, count};
   assign o_tlast  = last_line;
   assign o_tvalid = (state != chdr_pkg::IDLE) && (line_timer == '0);

endmodule

`default_nettype wire

// ==== rtl/axi_packet_gate.sv ====
// packet gate, buffers lines and releases only whole packets
// a packet can leave once its last line has been written
`timescale 1ns/1ps
`default_nettype none

`include "stream_consts.svh"

module axi_packet_gate
#(
   parameter int SIZE = `GATE_SIZE   // log2 depth in lines
)
(
   input  wire               clk,
   input  wire               reset,
   input  chdr_pkg::line_t   i_tdata,
   input  wire               i_tlast,
   input  wire               i_tvalid,
   output logic              o_tready,
   output chdr_pkg::line_t   o_tdata,
   output logic              o_tlast,
   output logic              o_tvalid,
   input  wire               i_tready
);

   typedef logic [SIZE-1:0] ptr_t;

   // each entry holds the last flag above the line
   logic [`LINE_W:0] mem [0:(1<<SIZE)-1];

   ptr_t wr_ptr;
   ptr_t commit_ptr;   // one past the last whole packet
   ptr_t rd_ptr;
   logic wr_en;
   logic rd_en;

   assign o_tready = (ptr_t'(wr_ptr + 1'b1) != rd_ptr);   // one slot kept free
   assign wr_en    = i_tvalid && o_tready;
   // refill output register when empty or being taken
   assign rd_en    = (rd_ptr != commit_ptr) && (!o_tvalid || i_tready);

   // **************************************************
   // write side
   // **************************************************
   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= {i_tlast, i_tdata};
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr     <= '0;
         commit_ptr <= '0;
      end
      else if (wr_en)
      begin
         wr_ptr <= wr_ptr + 1'b1;
         if (i_tlast)
            commit_ptr <= wr_ptr + 1'b1;   // packet complete
      end
   end

   // **************************************************
   // read side
   // **************************************************
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rd_ptr   <= '0;
         o_tvalid <= 1'b0;
         o_tlast  <= 1'b0;
      end
      else if (rd_en)
      begin
         rd_ptr   <= rd_ptr + 1'b1;
         o_tvalid <= 1'b1;
         o_tlast  <= mem[rd_ptr][`LINE_W];
      end
      else if (i_tready)
      begin
         o_tvalid <= 1'b0;
         o_tlast  <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rd_en)
         o_tdata <= mem[rd_ptr][`LINE_W-1:0];
   end

endmodule

`default_nettype wire

// ==== rtl/null_source_top.sv ====
// null stream source top level
// settings bank feeds the generator, output passes through the packet gate
`timescale 1ns/1ps
`default_nettype none

module null_source_top
(
   input  wire                       clk,
   input  wire                       reset,
   input  wire                       i_set_stb,
   input  settings_pkg::set_addr_t   i_set_addr,
   input  settings_pkg::set_data_t   i_set_data,
   output chdr_pkg::line_t           o_tdata,
   output logic                      o_tlast,
   output logic                      o_tvalid,
   input  wire                       i_tready
);

   chdr_pkg::sid_t              sid;
   settings_pkg::line_count_t   len;
   settings_pkg::rate_t         rate;
   logic                        enable;
   logic                        sid_changed;

   // generator to gate
   chdr_pkg::line_t             int_tdata;
   logic                        int_tlast;
   logic                        int_tvalid;
   logic                        int_tready;

   setting_bank setting_bank_inst
   (
      .clk           (clk),
      .reset         (reset),
      .i_set_stb     (i_set_stb),
      .i_set_addr    (i_set_addr),
      .i_set_data    (i_set_data),
      .o_sid         (sid),
      .o_len         (len),
      .o_rate        (rate),
      .o_enable      (enable),
      .o_sid_changed (sid_changed)
   );

   null_packet_gen null_packet_gen_inst
   (
      .clk           (clk),
      .reset         (reset),
      .i_sid         (sid),
      .i_len         (len),
      .i_rate        (rate),
      .i_enable      (enable),
      .i_sid_changed (sid_changed),
      .o_tdata       (int_tdata),
      .o_tlast       (int_tlast),
      .o_tvalid      (int_tvalid),
      .i_tready      (int_tready)
   );

   axi_packet_gate axi_packet_gate_inst
   (
      .clk      (clk),
      .reset    (reset),
      .i_tdata  (int_tdata),
      .i_tlast  (int_tlast),
      .i_tvalid (int_tvalid),
      .o_tready (int_tready),
      .o_tdata  (o_tdata),
      .o_tlast  (o_tlast),
      .o_tvalid (o_tvalid),
      .i_tready (i_tready)
   );

endmodule

`default_nettype wire

// ==== verification/null_source_tb.sv ====
// testbench for the null stream source
// runs a table of settings rows and checks every output line against a packet model
`timescale 1ns/1ps
`default_nettype none

`include "stream_consts.svh"

module null_source_tb;

   localparam int NUM_ROWS   = 6;
   localparam int WAIT_LIMIT = 5000;
   localparam int DRAIN_IDLE = 200;   // quiet cycles that end a drain

   typedef struct packed
   {
      logic [31:0] sid;
      logic [7:0]  len;
      logic [3:0]  rate;
      logic [7:0]  count;
      logic        write_sid;
      logic        ready_always;
   } row_t;

   logic                        clk;
   logic                        reset;
   logic                        i_set_stb;
   settings_pkg::set_addr_t     i_set_addr;
   settings_pkg::set_data_t     i_set_data;
   chdr_pkg::line_t             o_tdata;
   logic                        o_tlast;
   logic                        o_tvalid;
   logic                        i_tready;

   row_t                        rows [0:NUM_ROWS-1];
   logic [31:0]                 rng_state;
   logic                        ready_always;
   int                          cycle;

   // packet model
   chdr_pkg::sid_t              exp_sid;
   settings_pkg::line_count_t   exp_len;
   chdr_pkg::seqnum_t           exp_seq;
   settings_pkg::line_count_t   exp_index;   // 0 is the header
   int                          pkt_count;
   logic                        waiting_first;
   int                          enable_cycle;
   int                          first_delay;

   null_source_top null_source_top_inst
   (
      .clk        (clk),
      .reset      (reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_tdata    (o_tdata),
      .o_tlast    (o_tlast),
      .o_tvalid   (o_tvalid),
      .i_tready   (i_tready)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   always @(posedge clk)
      cycle <= cycle + 1;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // header or payload line from the packet format rules
   function automatic chdr_pkg::line_t expected_line(input settings_pkg::line_count_t index);
      chdr_pkg::pkt_len_t pkt_len;
      pkt_len = chdr_pkg::pkt_len_t'(exp_len * 8 + 8);
      if (index == 0)
         return {4'b0000, exp_seq, pkt_len, exp_sid};
      else
         return {~index, index, index, index};
   endfunction

   // **************************************************
   // failure reporting and checks
   // **************************************************
   task automatic abort_run();
      $display("Errors found");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic report_error(input string msg);
      $display("[ERROR] %0t %s", $time, msg);
      abort_run();
   endtask

   task automatic report_timeout(input string what);
      $display("timeout after %0d cycles while waiting for %s", WAIT_LIMIT, what);
      abort_run();
   endtask

   task automatic check_line(input chdr_pkg::line_t got, input chdr_pkg::line_t exp,
                             input string what);
      if (got !== exp)
         report_error($sformatf("%s: got %h expected %h", what, got, exp));
   endtask

   task automatic check_last(input logic got, input logic exp, input string what);
      if (got !== exp)
         report_error($sformatf("%s: got %b expected %b", what, got, exp));
   endtask

   task automatic check_seqnum(input chdr_pkg::seqnum_t got, input chdr_pkg::seqnum_t exp);
      if (got !== exp)
         report_error($sformatf("sequence number: got %0d expected %0d", got, exp));
   endtask

   // ready about 3 of 4 cycles unless the row holds it high
   always @(posedge clk)
   begin
      #1;
      if (ready_always)
         i_tready = 1'b1;
      else
      begin
         rng_state = xorshift(rng_state);
         i_tready  = (rng_state[1:0] != 2'b00);
      end
   end

   // output monitor, sampled mid cycle where outputs are stable
   always @(negedge clk)
   begin
      if (!reset && o_tvalid === 1'b1 && i_tready === 1'b1)
      begin
         if (exp_index == 0)
            check_seqnum(o_tdata[59:48], exp_seq);
         check_line(o_tdata, expected_line(exp_index),
                    $sformatf("packet %0d line %0d", exp_seq, exp_index));
         check_last(o_tlast, (exp_index == exp_len), "tlast");
         if (exp_index == exp_len)
         begin
            exp_index = '0;
            exp_seq   = exp_seq + 1'b1;
            pkt_count++;
         end
         else
            exp_index = exp_index + 1'b1;
      end
      else if (!reset && ready_always && exp_index != 0 && o_tvalid !== 1'b1)
         report_error("gap between lines of one packet while ready is held high");
      if (waiting_first && o_tvalid === 1'b1)
      begin
         first_delay   = cycle - enable_cycle;
         waiting_first = 1'b0;
      end
   end

   task automatic write_setting(input settings_pkg::set_addr_t addr,
                                input settings_pkg::set_data_t data);
      @(posedge clk);
      #1;
      i_set_stb  = 1'b1;
      i_set_addr = addr;
      i_set_data = data;
      @(posedge clk);
      #1;
      i_set_stb = 1'b0;
   endtask

   task automatic wait_packets(input int target);
      int guard;
      guard = 0;
      while (pkt_count < target)
      begin
         @(posedge clk);
         guard++;
         if (guard > WAIT_LIMIT)
            report_timeout("the requested packets at the output");
      end
   endtask

   task automatic drain_output();
      int quiet;
      int guard;
      quiet = 0;
      guard = 0;
      while (quiet < DRAIN_IDLE)
      begin
         @(negedge clk);
         if (o_tvalid === 1'b1)
            quiet = 0;
         else
            quiet++;
         guard++;
         if (guard > WAIT_LIMIT)
            report_timeout("the output to go quiet after enable was cleared");
      end
      if (exp_index != 0)
         report_error("packet in progress did not complete after enable was cleared");
   endtask

   // **************************************************
   // stimulus table and main loop
   // **************************************************
   initial
   begin
      int r;
      reset         = 1'b1;
      i_set_stb     = 1'b0;
      i_set_addr    = '0;
      i_set_data    = '0;
      i_tready      = 1'b0;
      ready_always  = 1'b0;
      rng_state     = 32'd26903;
      cycle         = 0;
      exp_sid       = '0;
      exp_len       = '0;
      exp_seq       = '0;
      exp_index     = '0;
      pkt_count     = 0;
      waiting_first = 1'b0;
      enable_cycle  = 0;
      first_delay   = 0;

      // sid, len, rate, packets, write sid, ready always
      rows[0] = {32'h0000_0A01, 8'd4,  4'd0, 8'd3, 1'b1, 1'b1};
      rows[1] = {32'h0000_0A01, 8'd8,  4'd2, 8'd2, 1'b0, 1'b0};   // seq continues
      rows[2] = {32'h00C0_FFEE, 8'd0,  4'd1, 8'd4, 1'b1, 1'b0};   // header only
      rows[3] = {32'h00C0_FFEE, 8'd16, 4'd3, 8'd2, 1'b0, 1'b0};
      rows[4] = {32'h1234_5678, 8'd1,  4'd0, 8'd5, 1'b1, 1'b1};
      rows[5] = {32'h1234_5678, 8'd12, 4'd1, 8'd3, 1'b1, 1'b1};   // same sid rewritten

      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      check_last(o_tvalid, 1'b0, "o_tvalid after reset");
      check_last(o_tlast, 1'b0, "o_tlast after reset");

      for (r = 0; r < NUM_ROWS; r++)
      begin
         @(negedge clk);
         ready_always = rows[r].ready_always;
         exp_sid      = rows[r].sid;
         exp_len      = rows[r].len;
         exp_index    = '0;
         pkt_count    = 0;
         if (rows[r].write_sid)
         begin
            exp_seq = '0;
            write_setting(`SR_NEXT_DST, rows[r].sid);
         end
         write_setting(`SR_LINES_PER_PACKET, rows[r].len);
         write_setting(`SR_LINE_RATE, rows[r].rate);
         write_setting(`SR_ENABLE_STREAM, 32'd1);
         enable_cycle  = cycle;
         waiting_first = 1'b1;
         wait_packets(rows[r].count);
         write_setting(`SR_ENABLE_STREAM, 32'd0);
         drain_output();
         if (rows[r].rate != 0 && first_delay < int'(rows[r].len) * (int'(rows[r].rate) + 1))
            report_error($sformatf("row %0d first line after %0d cycles, too early", r,
                                   first_delay));
      end

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+rtl
rtl/settings_pkg.sv
rtl/chdr_pkg.sv
rtl/setting_bank.sv
rtl/null_packet_gen.sv
rtl/axi_packet_gate.sv
rtl/null_source_top.sv
verification/null_source_tb.sv

// ==== Bender.yml ====
package:
  name: null_source

export_include_dirs:
  - rtl

sources:
  - target: rtl
    include_dirs:
      - rtl
    files:
      - rtl/settings_pkg.sv
      - rtl/chdr_pkg.sv
      - rtl/setting_bank.sv
      - rtl/null_packet_gen.sv
      - rtl/axi_packet_gate.sv
      - rtl/null_source_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/null_source_tb.sv
